/* Bender.yml */
package:
  name: wmb_ce

sources:
  # Package first, then leaf blocks, then the top level
  - files:
      - wmb_ce_pkg.sv
      - wmb_ce_entry.sv
      - wmb_ce_decode.sv
      - wmb_ce_req.sv
      - wmb_ce_cmp.sv
      - wmb_ce_top.sv

  - target: simulation
    files:
      - tb_wmb_ce.sv

/* tb_wmb_ce.sv */
// Testbench for the write merge buffer create-entry stage
// Applies a table of store-queue entries and checks requests,
// class flags and pop compare results, then pop and flush release

`timescale 1ns/10ps
`default_nettype none

module tb_wmb_ce import wmb_ce_pkg::*; ();

  localparam int NUM_ROWS  = 12;
  localparam int NUM_FLAGS = 20;
  localparam int WAIT_MAX  = 16;

  // Flag bits are atomic, icc, sync fence and wo_st
  // Page bits are ca, so, share, merge and stall
  // State bits are dcache_valid, dcache_share and sc_fail
  typedef struct packed {
    logic [39:0] addr;
    logic [15:0] bytes;
    logic [3:0]  flags;
    logic [1:0]  itype;
    logic [1:0]  imode;
    logic [2:0]  isize;
    logic [1:0]  priv;
    logic [4:0]  page;
    logic [7:0]  ptr;
    logic [7:0]  entry_vld;
    logic [2:0]  state;
    logic [39:0] nxt_addr;
    logic [1:0]  nxt_priv;
    logic [19:0] exp;
    logic [3:0]  exp_dvld;
  } row_t;

  logic       wmb_clk, cpurst_b, sq_create, wmb_pop, async_flush;
  pa_t        sq_pop_addr;
  bytes_vld_t sq_pop_bytes_vld;
  logic       sq_pop_atomic, sq_pop_icc, sq_pop_sync_fence, sq_pop_wo_st;
  inst_type_t sq_pop_inst_type;
  inst_mode_t sq_pop_inst_mode;
  inst_size_t sq_pop_inst_size;
  priv_t      sq_pop_priv_mode;
  logic       sq_pop_page_ca, sq_pop_page_so, sq_pop_page_share;
  logic       create_merge, create_stall;
  wmb_ptr_t   create_merge_ptr, wmb_entry_vld;
  logic       dcache_valid, dcache_share, sc_fail;
  logic       ce_vld, dcache_inst, dcache_sw_inst;
  logic       create_wmb_req, create_dp_req, create_data_req;
  logic       merge_wmb_req, merge_wait_req, read_dp_req, write_biu_req;
  logic       wb_cmplt_success, wb_data_success, merge_en, write_imme;
  logic       ca_st_inst, bytes_vld_full, sc_wb_vld;
  data_vld_t  data_vld;
  logic       hit_sq_pop_line, merge_addr_hit, merge_data_stall;

  row_t   rows [0:NUM_ROWS-1];
  string  flag_names [0:NUM_FLAGS-1];
  integer seed;
  integer errors;
  integer checks;

  wmb_ce_top i_wmb_ce_top (.*);

  initial
  begin
    wmb_clk = 1'b0;
    forever #50 wmb_clk = ~wmb_clk;
  end

  // Watchdog for the whole run
  initial
  begin
    #200000;
    $display("Run did not complete within the time limit");
    $display("Some tests failed");
    $finish;
  end

  //====================
  // Helpers
  //====================
  task automatic next_cycle();
    @(posedge wmb_clk);
    #5;
  endtask

  task automatic check_val(input string name, input logic [39:0] exp, input logic [39:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  // Poll ce_vld for a level within WAIT_MAX cycles
  task automatic wait_vld(input logic level);
    int n;
    n = 0;
    while (ce_vld !== level && n < WAIT_MAX)
    begin
      next_cycle();
      n++;
    end
    if (ce_vld !== level)
    begin
      errors++;
      $display("Timeout at %0t: ce_vld never reached %0b", $time, level);
    end
  endtask

  function automatic logic [19:0] out_flags();
    return {ce_vld, dcache_inst, dcache_sw_inst, create_wmb_req,
            create_dp_req, create_data_req, merge_wmb_req, merge_wait_req,
            read_dp_req, write_biu_req, wb_cmplt_success, wb_data_success,
            merge_en, write_imme, ca_st_inst, bytes_vld_full,
            sc_wb_vld, hit_sq_pop_line, merge_addr_hit, merge_data_stall};
  endfunction

  // Valid bit and every request low
  task automatic check_idle();
    check_val("ce_vld", 0, ce_vld);
    check_val("create_wmb_req", 0, create_wmb_req);
    check_val("create_dp_req", 0, create_dp_req);
    check_val("create_data_req", 0, create_data_req);
    check_val("merge_wmb_req", 0, merge_wmb_req);
    check_val("merge_wait_req", 0, merge_wait_req);
    check_val("read_dp_req", 0, read_dp_req);
    check_val("write_biu_req", 0, write_biu_req);
  endtask

  task automatic drive_fields(input row_t r);
    logic [3:0] low;
    low = 4'($random(seed));
    sq_pop_addr       = {r.addr[39:4], low};
    sq_pop_bytes_vld  = r.bytes;
    {sq_pop_atomic, sq_pop_icc, sq_pop_sync_fence, sq_pop_wo_st} = r.flags;
    sq_pop_inst_type  = r.itype;
    sq_pop_inst_mode  = r.imode;
    sq_pop_inst_size  = r.isize;
    sq_pop_priv_mode  = r.priv;
    {sq_pop_page_ca, sq_pop_page_so, sq_pop_page_share, create_merge, create_stall} = r.page;
    create_merge_ptr  = r.ptr;
    wmb_entry_vld     = r.entry_vld;
    {dcache_valid, dcache_share, sc_fail} = r.state;
  endtask

  // Create, present the next pop, check everything, then pop
  task automatic apply_row(input row_t r);
    logic [3:0]  low;
    logic [19:0] act;
    drive_fields(r);
    sq_create = 1'b1;
    next_cycle();
    sq_create = 1'b0;
    low = 4'($random(seed));
    sq_pop_addr = {r.nxt_addr[39:4], low};
    sq_pop_priv_mode = r.nxt_priv;
    wait_vld(1'b1);
    #20;
    act = out_flags();
    for (int k = 0; k < NUM_FLAGS; k++)
      check_val(flag_names[k], r.exp[NUM_FLAGS-1-k], act[NUM_FLAGS-1-k]);
    check_val("data_vld", r.exp_dvld, data_vld);
    next_cycle();
    wmb_pop = 1'b1;
    next_cycle();
    wmb_pop = 1'b0;
    wait_vld(1'b0);
    #20;
    check_idle();
  endtask

  task automatic load_table();
    flag_names = '{"ce_vld", "dcache_inst", "dcache_sw_inst", "create_wmb_req",
                   "create_dp_req", "create_data_req", "merge_wmb_req", "merge_wait_req",
                   "read_dp_req", "write_biu_req", "wb_cmplt_success", "wb_data_success",
                   "merge_en", "write_imme", "ca_st_inst", "bytes_vld_full",
                   "sc_wb_vld", "hit_sq_pop_line", "merge_addr_hit", "merge_data_stall"};
    // Cacheable stores with compare against the next pop
    rows[0]  = {40'h00_1234_5670, 16'hffff, 4'b0001, 2'd0, 2'd0, 3'd0, 2'd3, 5'b10000,
                8'h00, 8'h00, 3'b100, 40'h00_1234_5678, 2'd3, 20'b1001_1100_0011_1011_0110, 4'hf};
    rows[1]  = {40'h00_1234_5670, 16'h00f0, 4'b0001, 2'd0, 2'd0, 3'd0, 2'd3, 5'b10110,
                8'h04, 8'h04, 3'b110, 40'h00_1234_5670, 2'd0, 20'b1000_0010_1011_1010_0111, 4'h2};
    rows[2]  = {40'h00_8000_0000, 16'h0001, 4'b0000, 2'd0, 2'd0, 3'd0, 2'd1, 5'b01011,
                8'h10, 8'h00, 3'b000, 40'h00_8000_0100, 2'd1, 20'b1001_1101_0101_0100_0000, 4'h1};
    rows[3]  = {40'h00_0000_1000, 16'hff00, 4'b0001, 2'd0, 2'd0, 3'd0, 2'd3, 5'b10100,
                8'h00, 8'h00, 3'b000, 40'h00_0000_1020, 2'd3, 20'b1001_1100_1111_1010_0100, 4'hc};
    // Atomics and fence
    rows[4]  = {40'h00_2000_0040, 16'h000f, 4'b1000, 2'd1, 2'd0, 3'd2, 2'd3, 5'b10100,
                8'h00, 8'h00, 3'b101, 40'h00_2000_0040, 2'd3, 20'b1001_1100_1000_0100_1000, 4'h1};
    rows[5]  = {40'h00_2000_0080, 16'h0ff0, 4'b1000, 2'd1, 2'd0, 3'd2, 2'd0, 5'b00010,
                8'h00, 8'hff, 3'b000, 40'h00_2000_0080, 2'd0, 20'b1000_0010_0100_0100_0000, 4'h6};
    rows[6]  = {40'h00_3000_0000, 16'h0000, 4'b1000, 2'd0, 2'd0, 3'd2, 2'd3, 5'b10000,
                8'h00, 8'h00, 3'b000, 40'h00_3000_0000, 2'd3, 20'b1001_1100_0101_0100_0000, 4'h0};
    rows[7]  = {40'h00_3000_0100, 16'h0000, 4'b0010, 2'd0, 2'd0, 3'd0, 2'd3, 5'b00000,
                8'h00, 8'h00, 3'b000, 40'h00_3000_0100, 2'd3, 20'b1001_1000_0101_0100_0000, 4'h0};
    // Cache maintenance
    rows[8]  = {40'h00_4000_0000, 16'h0000, 4'b0100, 2'd1, 2'd0, 3'd0, 2'd3, 5'b00000,
                8'h00, 8'h00, 3'b000, 40'h00_4000_0000, 2'd3, 20'b1001_1000_1011_0100_0000, 4'h0};
    rows[9]  = {40'h00_4000_0040, 16'h0000, 4'b0100, 2'd2, 2'd1, 3'd1, 2'd3, 5'b10000,
                8'h00, 8'h00, 3'b000, 40'h00_4000_0040, 2'd3, 20'b1101_1000_1011_0100_0000, 4'h0};
    rows[10] = {40'h00_4000_0080, 16'h0000, 4'b0100, 2'd2, 2'd2, 3'd0, 2'd3, 5'b10000,
                8'h00, 8'h00, 3'b000, 40'h00_4000_0080, 2'd3, 20'b1111_1000_0011_0100_0000, 4'h0};
    rows[11] = {40'h00_4000_00c0, 16'h0000, 4'b0100, 2'd2, 2'd0, 3'd0, 2'd3, 5'b10000,
                8'h00, 8'h00, 3'b000, 40'h00_4000_00c0, 2'd3, 20'b1101_1000_0001_0100_0000, 4'h0};
  endtask

  //====================
  // Main sequence
  //====================
  initial
  begin
    seed = 12568;
    errors = 0;
    checks = 0;
    cpurst_b = 1'b0;
    sq_create = 1'b0;
    wmb_pop = 1'b0;
    async_flush = 1'b0;
    drive_fields('0);
    load_table();
    repeat (10) @(posedge wmb_clk);
    #5;
    cpurst_b = 1'b1;
    #20;
    check_idle();
    next_cycle();
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      apply_row(rows[i]);
      next_cycle();
    end
    // Flush together with create leaves the entry empty
    drive_fields(rows[0]);
    sq_create = 1'b1;
    async_flush = 1'b1;
    next_cycle();
    sq_create = 1'b0;
    async_flush = 1'b0;
    #20;
    check_idle();
    // Flush of a held entry
    next_cycle();
    sq_create = 1'b1;
    next_cycle();
    sq_create = 1'b0;
    wait_vld(1'b1);
    async_flush = 1'b1;
    next_cycle();
    async_flush = 1'b0;
    wait_vld(1'b0);
    #20;
    check_idle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
wmb_ce_pkg.sv
wmb_ce_entry.sv
wmb_ce_decode.sv
wmb_ce_req.sv
wmb_ce_cmp.sv
wmb_ce_top.sv
tb_wmb_ce.sv

/* wmb_ce_cmp.sv */
// Compare of the held entry against the current store-queue pop
// Reports same-line hit, merge address hit and privilege stall

`timescale 1ns/10ps
`default_nettype none

module wmb_ce_cmp import wmb_ce_pkg::*; (
  input  logic  ce_vld,
  input  pa_t   ce_addr,
  input  priv_t ce_priv_mode,
  input  logic  ce_wo_st,
  input  logic  st_inst,
  input  pa_t   sq_pop_addr,
  input  priv_t sq_pop_priv_mode,
  output logic  hit_sq_pop_line,
  output logic  merge_addr_hit,
  output logic  merge_data_stall
);

  logic line_match;
  logic granule_match;

  assign line_match    = ce_addr[PA_WIDTH-1:LINE_LSB] == sq_pop_addr[PA_WIDTH-1:LINE_LSB];
  // Granule bits below the line boundary
  assign granule_match = line_match
                      && (ce_addr[LINE_LSB-1:MERGE_LSB] == sq_pop_addr[LINE_LSB-1:MERGE_LSB]);

  assign hit_sq_pop_line = ce_vld && st_inst && line_match;
  assign merge_addr_hit  = ce_vld && ce_wo_st && granule_match;

  // Merge blocked across privilege modes
  assign merge_data_stall = merge_addr_hit && (ce_priv_mode != sq_pop_priv_mode);

endmodule

`default_nettype wire

/* wmb_ce_decode.sv */
// Instruction class decode for the held create entry
// Splits stores, atomics, fences and cache ops by type and mode

`timescale 1ns/10ps
`default_nettype none

module wmb_ce_decode import wmb_ce_pkg::*; (
  input  logic       ce_atomic,
  input  logic       ce_icc,
  input  logic       ce_sync_fence,
  input  inst_type_t ce_inst_type,
  input  inst_mode_t ce_inst_mode,
  input  inst_size_t ce_inst_size,
  output logic       st_inst,
  output logic       sc_inst,
  output logic       stamo_inst,
  output logic       sync_fence_inst,
  output logic       ctc_inst,
  output logic       dcache_inst,
  output logic       dcache_sw_inst,
  output logic       dcache_addr_inst,
  output logic       dcache_all_inst,
  output logic       addr_not_l1_inst
);

  logic icc_op;

  //====================
  // Store and atomic
  //====================
  // Plain store carries none of the special flags
  assign st_inst    = !ce_atomic && !ce_icc && !ce_sync_fence;
  assign sc_inst    = ce_atomic && (ce_inst_type == TYPE_SC);
  assign stamo_inst = ce_atomic && (ce_inst_type == TYPE_STAMO);

  assign sync_fence_inst = !ce_atomic && ce_sync_fence;

  //====================
  // Cache maintenance
  //====================
  assign icc_op = !ce_atomic && ce_icc;

  assign dcache_inst = icc_op && (ce_inst_type == TYPE_DCACHE);
  // Any other icc type goes to the cache/TLB controller
  assign ctc_inst    = icc_op && (ce_inst_type != TYPE_DCACHE);

  assign dcache_all_inst  = dcache_inst && (ce_inst_mode == MODE_ALL);
  assign dcache_sw_inst   = dcache_inst && (ce_inst_mode == MODE_SW);
  assign dcache_addr_inst = dcache_inst && ce_inst_mode[0];

  // Address op reaching past L1
  assign addr_not_l1_inst = dcache_addr_inst && (ce_inst_size[1:0] != 2'b00);

endmodule

`default_nettype wire

/* wmb_ce_entry.sv */
// Create-entry capture register
// Holds one retiring store-queue entry from create until pop or flush

`timescale 1ns/10ps
`default_nettype none

module wmb_ce_entry import wmb_ce_pkg::*; (
  input  logic       wmb_clk,
  input  logic       cpurst_b,
  input  logic       sq_create,
  input  logic       wmb_pop,
  input  logic       async_flush,
  input  pa_t        sq_pop_addr,
  input  bytes_vld_t sq_pop_bytes_vld,
  input  logic       sq_pop_atomic,
  input  logic       sq_pop_icc,
  input  logic       sq_pop_sync_fence,
  input  logic       sq_pop_wo_st,
  input  inst_type_t sq_pop_inst_type,
  input  inst_mode_t sq_pop_inst_mode,
  input  inst_size_t sq_pop_inst_size,
  input  priv_t      sq_pop_priv_mode,
  input  logic       sq_pop_page_ca,
  input  logic       sq_pop_page_so,
  input  logic       sq_pop_page_share,
  input  logic       create_merge,
  input  logic       create_stall,
  input  wmb_ptr_t   create_merge_ptr,
  output logic       ce_vld,
  output pa_t        ce_addr,
  output bytes_vld_t ce_bytes_vld,
  output logic       ce_atomic,
  output logic       ce_icc,
  output logic       ce_sync_fence,
  output logic       ce_wo_st,
  output inst_type_t ce_inst_type,
  output inst_mode_t ce_inst_mode,
  output inst_size_t ce_inst_size,
  output priv_t      ce_priv_mode,
  output logic       ce_page_ca,
  output logic       ce_page_so,
  output logic       ce_page_share,
  output logic       ce_merge,
  output logic       ce_stall,
  output wmb_ptr_t   ce_merge_ptr
);

  // Flush wins over create, create wins over pop
  always_ff @(posedge wmb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ce_vld <= 1'b0;
    else if (async_flush)
      ce_vld <= 1'b0;
    else if (sq_create)
      ce_vld <= 1'b1;
    else if (wmb_pop)
      ce_vld <= 1'b0;
  end

  // Held store fields and merge decision
  always_ff @(posedge wmb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ce_addr       <= '0;
      ce_bytes_vld  <= '0;
      ce_atomic     <= 1'b0;
      ce_icc        <= 1'b0;
      ce_sync_fence <= 1'b0;
      ce_wo_st      <= 1'b0;
      ce_inst_type  <= '0;
      ce_inst_mode  <= '0;
      ce_inst_size  <= '0;
      ce_priv_mode  <= '0;
      ce_page_ca    <= 1'b0;
      ce_page_so    <= 1'b0;
      ce_page_share <= 1'b0;
      ce_merge      <= 1'b0;
      ce_stall      <= 1'b0;
      ce_merge_ptr  <= '0;
    end
    else if (sq_create)
    begin
      ce_addr       <= sq_pop_addr;
      ce_bytes_vld  <= sq_pop_bytes_vld;
      ce_atomic     <= sq_pop_atomic;
      ce_icc        <= sq_pop_icc;
      ce_sync_fence <= sq_pop_sync_fence;
      ce_wo_st      <= sq_pop_wo_st;
      ce_inst_type  <= sq_pop_inst_type;
      ce_inst_mode  <= sq_pop_inst_mode;
      ce_inst_size  <= sq_pop_inst_size;
      ce_priv_mode  <= sq_pop_priv_mode;
      ce_page_ca    <= sq_pop_page_ca;
      ce_page_so    <= sq_pop_page_so;
      ce_page_share <= sq_pop_page_share;
      ce_merge      <= create_merge;
      ce_stall      <= create_stall;
      ce_merge_ptr  <= create_merge_ptr;
    end
  end

  // Merge target picks at most one buffer entry
  a_merge_ptr_onehot: assert property (
    @(posedge wmb_clk) disable iff (!cpurst_b)
    sq_create |-> $onehot0(create_merge_ptr)
  );

endmodule

`default_nettype wire

/* wmb_ce_pkg.sv */
// Write merge buffer create-entry stage
// Shared widths, field types and instruction encodings

`default_nettype none

package wmb_ce_pkg;

  //====================
  // Widths
  //====================
  localparam int PA_WIDTH  = 40;
  localparam int BYTES_W   = 16;
  localparam int WORD_NUM  = 4;
  localparam int WMB_ENTRY = 8;

  // Cache line and merge granule boundaries in the address
  localparam int LINE_LSB  = 6;
  localparam int MERGE_LSB = 4;

  //====================
  // Field types
  //====================
  typedef logic [PA_WIDTH-1:0]  pa_t;
  typedef logic [BYTES_W-1:0]   bytes_vld_t;
  typedef logic [WORD_NUM-1:0]  data_vld_t;
  typedef logic [WMB_ENTRY-1:0] wmb_ptr_t;
  typedef logic [1:0]           inst_type_t;
  typedef logic [1:0]           inst_mode_t;
  typedef logic [2:0]           inst_size_t;
  typedef logic [1:0]           priv_t;

  //====================
  // Encodings
  //====================
  // Instruction type, atomic or cache maintenance
  localparam inst_type_t TYPE_STAMO  = 2'd0;
  localparam inst_type_t TYPE_SC     = 2'd1;
  localparam inst_type_t TYPE_DCACHE = 2'd2;

  // Cache op mode, bit 0 set selects an address-based op
  localparam inst_mode_t MODE_ALL = 2'd0;
  localparam inst_mode_t MODE_SW  = 2'd2;

endpackage

`default_nettype wire

/* wmb_ce_req.sv */
// Request generation for the create entry
// Drives create, merge, read and write requests to the merge buffer

`timescale 1ns/10ps
`default_nettype none

module wmb_ce_req import wmb_ce_pkg::*; (
  input  logic       wmb_clk,
  input  logic       cpurst_b,
  input  logic       ce_vld,
  input  logic       ce_atomic,
  input  logic       ce_wo_st,
  input  logic       ce_page_ca,
  input  logic       ce_page_so,
  input  logic       ce_page_share,
  input  logic       ce_merge,
  input  logic       ce_stall,
  input  wmb_ptr_t   ce_merge_ptr,
  input  bytes_vld_t ce_bytes_vld,
  input  logic       st_inst,
  input  logic       sc_inst,
  input  logic       stamo_inst,
  input  logic       sync_fence_inst,
  input  logic       ctc_inst,
  input  logic       dcache_inst,
  input  logic       dcache_addr_inst,
  input  logic       dcache_all_inst,
  input  logic       addr_not_l1_inst,
  input  wmb_ptr_t   wmb_entry_vld,
  input  logic       dcache_valid,
  input  logic       dcache_share,
  input  logic       sc_fail,
  output logic       create_wmb_req,
  output logic       create_dp_req,
  output logic       create_data_req,
  output logic       merge_wmb_req,
  output logic       merge_wait_req,
  output logic       read_dp_req,
  output logic       write_biu_req,
  output logic       wb_cmplt_success,
  output logic       wb_data_success,
  output logic       merge_en,
  output logic       write_imme,
  output logic       ca_st_inst,
  output logic       bytes_vld_full,
  output logic       sc_wb_vld,
  output data_vld_t  data_vld
);

  logic merge_not_vld;
  logic ca_hit;
  logic biu_inst;
  logic read_inst;

  //====================
  // Create and merge
  //====================
  // Merge target already retired from the buffer
  assign merge_not_vld = |(ce_merge_ptr & ~wmb_entry_vld);

  assign create_wmb_req  = ce_vld && (!ce_merge || merge_not_vld);
  assign merge_wmb_req   = ce_vld && ce_merge && !ce_stall;
  assign merge_wait_req  = ce_vld && ce_merge && ce_stall;
  assign create_dp_req   = ce_vld && (!ce_merge || ce_stall);
  assign create_data_req = create_dp_req && (ce_atomic || st_inst);

  // Word valids from byte enables
  for (genvar i = 0; i < WORD_NUM; i++)
  begin : g_word
    assign data_vld[i] = |ce_bytes_vld[i*(BYTES_W/WORD_NUM) +: BYTES_W/WORD_NUM];
  end

  assign bytes_vld_full = &ce_bytes_vld;
  assign merge_en       = ce_wo_st;
  assign write_imme     = !ce_wo_st;
  assign ca_st_inst     = st_inst && ce_page_ca;
  assign sc_wb_vld      = sc_fail;

  //====================
  // Bus and data path
  //====================
  // Line present in a cacheable page, write stays local
  assign ca_hit = ce_page_ca && dcache_valid;

  assign biu_inst = st_inst && ce_page_so
                 || st_inst && !ce_page_so && !ca_hit
                 || sync_fence_inst
                 || stamo_inst && !ca_hit
                 || sc_inst && !ca_hit && !sc_fail;

  assign read_inst = st_inst && ce_page_ca && ce_page_share && (dcache_share || !dcache_valid)
                  || ctc_inst
                  || dcache_addr_inst && ce_page_ca && (addr_not_l1_inst || ce_page_share)
                  || sc_inst && ce_page_ca && ce_page_share;

  assign write_biu_req = ce_vld && biu_inst;
  assign read_dp_req   = ce_vld && read_inst;

  // Completion status reported back with the entry
  assign wb_cmplt_success = ce_wo_st || ctc_inst || (dcache_inst && !dcache_all_inst);
  assign wb_data_success  = !sc_inst;

  // Requests only come from a held entry
  a_no_req_idle: assert property (
    @(posedge wmb_clk) disable iff (!cpurst_b)
    !ce_vld |-> !(create_wmb_req || create_dp_req || create_data_req || merge_wmb_req
                  || merge_wait_req || read_dp_req || write_biu_req)
  );

endmodule

`default_nettype wire

/* wmb_ce_top.sv */
// Write merge buffer create-entry stage
// Connects capture register, class decode, request and compare logic

`timescale 1ns/10ps
`default_nettype none

module wmb_ce_top import wmb_ce_pkg::*; (
  input  logic       wmb_clk,
  input  logic       cpurst_b,
  input  pa_t        sq_pop_addr,
  input  bytes_vld_t sq_pop_bytes_vld,
  input  logic       sq_pop_atomic,
  input  logic       sq_pop_icc,
  input  logic       sq_pop_sync_fence,
  input  logic       sq_pop_wo_st,
  input  inst_type_t sq_pop_inst_type,
  input  inst_mode_t sq_pop_inst_mode,
  input  inst_size_t sq_pop_inst_size,
  input  priv_t      sq_pop_priv_mode,
  input  logic       sq_pop_page_ca,
  input  logic       sq_pop_page_so,
  input  logic       sq_pop_page_share,
  input  logic       create_merge,
  input  logic       create_stall,
  input  wmb_ptr_t   create_merge_ptr,
  input  logic       sq_create,
  input  logic       wmb_pop,
  input  logic       async_flush,
  input  wmb_ptr_t   wmb_entry_vld,
  input  logic       dcache_valid,
  input  logic       dcache_share,
  input  logic       sc_fail,
  output logic       ce_vld,
  output logic       dcache_inst,
  output logic       dcache_sw_inst,
  output logic       create_wmb_req,
  output logic       create_dp_req,
  output logic       create_data_req,
  output logic       merge_wmb_req,
  output logic       merge_wait_req,
  output logic       read_dp_req,
  output logic       write_biu_req,
  output logic       wb_cmplt_success,
  output logic       wb_data_success,
  output logic       merge_en,
  output logic       write_imme,
  output logic       ca_st_inst,
  output logic       bytes_vld_full,
  output logic       sc_wb_vld,
  output data_vld_t  data_vld,
  output logic       hit_sq_pop_line,
  output logic       merge_addr_hit,
  output logic       merge_data_stall
);

  // Held entry fields
  pa_t        ce_addr;
  bytes_vld_t ce_bytes_vld;
  logic       ce_atomic;
  logic       ce_icc;
  logic       ce_sync_fence;
  logic       ce_wo_st;
  inst_type_t ce_inst_type;
  inst_mode_t ce_inst_mode;
  inst_size_t ce_inst_size;
  priv_t      ce_priv_mode;
  logic       ce_page_ca;
  logic       ce_page_so;
  logic       ce_page_share;
  logic       ce_merge;
  logic       ce_stall;
  wmb_ptr_t   ce_merge_ptr;

  // Instruction classes
  logic st_inst;
  logic sc_inst;
  logic stamo_inst;
  logic sync_fence_inst;
  logic ctc_inst;
  logic dcache_addr_inst;
  logic dcache_all_inst;
  logic addr_not_l1_inst;

  wmb_ce_entry i_wmb_ce_entry (
    .wmb_clk           (wmb_clk),
    .cpurst_b          (cpurst_b),
    .sq_create         (sq_create),
    .wmb_pop           (wmb_pop),
    .async_flush       (async_flush),
    .sq_pop_addr       (sq_pop_addr),
    .sq_pop_bytes_vld  (sq_pop_bytes_vld),
    .sq_pop_atomic     (sq_pop_atomic),
    .sq_pop_icc        (sq_pop_icc),
    .sq_pop_sync_fence (sq_pop_sync_fence),
    .sq_pop_wo_st      (sq_pop_wo_st),
    .sq_pop_inst_type  (sq_pop_inst_type),
    .sq_pop_inst_mode  (sq_pop_inst_mode),
    .sq_pop_inst_size  (sq_pop_inst_size),
    .sq_pop_priv_mode  (sq_pop_priv_mode),
    .sq_pop_page_ca    (sq_pop_page_ca),
    .sq_pop_page_so    (sq_pop_page_so),
    .sq_pop_page_share (sq_pop_page_share),
    .create_merge      (create_merge),
    .create_stall      (create_stall),
    .create_merge_ptr  (create_merge_ptr),
    .ce_vld            (ce_vld),
    .ce_addr           (ce_addr),
    .ce_bytes_vld      (ce_bytes_vld),
    .ce_atomic         (ce_atomic),
    .ce_icc            (ce_icc),
    .ce_sync_fence     (ce_sync_fence),
    .ce_wo_st          (ce_wo_st),
    .ce_inst_type      (ce_inst_type),
    .ce_inst_mode      (ce_inst_mode),
    .ce_inst_size      (ce_inst_size),
    .ce_priv_mode      (ce_priv_mode),
    .ce_page_ca        (ce_page_ca),
    .ce_page_so        (ce_page_so),
    .ce_page_share     (ce_page_share),
    .ce_merge          (ce_merge),
    .ce_stall          (ce_stall),
    .ce_merge_ptr      (ce_merge_ptr)
  );

  wmb_ce_decode i_wmb_ce_decode (
    .ce_atomic        (ce_atomic),
    .ce_icc           (ce_icc),
    .ce_sync_fence    (ce_sync_fence),
    .ce_inst_type     (ce_inst_type),
    .ce_inst_mode     (ce_inst_mode),
    .ce_inst_size     (ce_inst_size),
    .st_inst          (st_inst),
    .sc_inst          (sc_inst),
    .stamo_inst       (stamo_inst),
    .sync_fence_inst  (sync_fence_inst),
    .ctc_inst         (ctc_inst),
    .dcache_inst      (dcache_inst),
    .dcache_sw_inst   (dcache_sw_inst),
    .dcache_addr_inst (dcache_addr_inst),
    .dcache_all_inst  (dcache_all_inst),
    .addr_not_l1_inst (addr_not_l1_inst)
  );

  wmb_ce_req i_wmb_ce_req (
    .wmb_clk          (wmb_clk),
    .cpurst_b         (cpurst_b),
    .ce_vld           (ce_vld),
    .ce_atomic        (ce_atomic),
    .ce_wo_st         (ce_wo_st),
    .ce_page_ca       (ce_page_ca),
    .ce_page_so       (ce_page_so),
    .ce_page_share    (ce_page_share),
    .ce_merge         (ce_merge),
    .ce_stall         (ce_stall),
    .ce_merge_ptr     (ce_merge_ptr),
    .ce_bytes_vld     (ce_bytes_vld),
    .st_inst          (st_inst),
    .sc_inst          (sc_inst),
    .stamo_inst       (stamo_inst),
    .sync_fence_inst  (sync_fence_inst),
    .ctc_inst         (ctc_inst),
    .dcache_inst      (dcache_inst),
    .dcache_addr_inst (dcache_addr_inst),
    .dcache_all_inst  (dcache_all_inst),
    .addr_not_l1_inst (addr_not_l1_inst),
    .wmb_entry_vld    (wmb_entry_vld),
    .dcache_valid     (dcache_valid),
    .dcache_share     (dcache_share),
    .sc_fail          (sc_fail),
    .create_wmb_req   (create_wmb_req),
    .create_dp_req    (create_dp_req),
    .create_data_req  (create_data_req),
    .merge_wmb_req    (merge_wmb_req),
    .merge_wait_req   (merge_wait_req),
    .read_dp_req      (read_dp_req),
    .write_biu_req    (write_biu_req),
    .wb_cmplt_success (wb_cmplt_success),
    .wb_data_success  (wb_data_success),
    .merge_en         (merge_en),
    .write_imme       (write_imme),
    .ca_st_inst       (ca_st_inst),
    .bytes_vld_full   (bytes_vld_full),
    .sc_wb_vld        (sc_wb_vld),
    .data_vld         (data_vld)
  );

  wmb_ce_cmp i_wmb_ce_cmp (
    .ce_vld           (ce_vld),
    .ce_addr          (ce_addr),
    .ce_priv_mode     (ce_priv_mode),
    .ce_wo_st         (ce_wo_st),
    .st_inst          (st_inst),
    .sq_pop_addr      (sq_pop_addr),
    .sq_pop_priv_mode (sq_pop_priv_mode),
    .hit_sq_pop_line  (hit_sq_pop_line),
    .merge_addr_hit   (merge_addr_hit),
    .merge_data_stall (merge_data_stall)
  );

endmodule

`default_nettype wire
